//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module exu_tb -f sim.f -o exu_sim \
  && ./obj_dir/exu_sim > sim.log 2>&1 \
  && grep -qxF '*** PASSED ***' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim.f
+incdir+include
source/exu_pkg.sv
source/reg_file.sv
source/exu_issue.sv
source/alu.sv
source/lsu.sv
source/exu_commit.sv
source/exu_top.sv
verif/tb_clock.sv
verif/exu_tb.sv

//--- source/alu.sv
module alu (
  input  logic [exu_pkg::xlen-1:0] alu_a,
  input  logic [exu_pkg::xlen-1:0] alu_b,
  input  exu_pkg::alu_mode_t       alu_mode,
  input  logic                     alu_word,
  output logic [exu_pkg::xlen-1:0] alu_result
);

  logic [exu_pkg::xlen-1:0] a;
  logic [exu_pkg::xlen-1:0] b;
  logic [5:0]               shamt;
  logic [exu_pkg::xlen-1:0] raw;

  // word forms work on the sign-extended low halves
  assign a = alu_word ? {{32{alu_a[31]}}, alu_a[31:0]} : alu_a;
  assign b = alu_word ? {{32{alu_b[31]}}, alu_b[31:0]} : alu_b;

  assign shamt = alu_word ? {1'b0, alu_b[4:0]} : alu_b[5:0];

  always_comb begin
    case (alu_mode)
      exu_pkg::mode_add:  raw = a + b;
      exu_pkg::mode_sub:  raw = a - b;
      exu_pkg::mode_sltu: raw = {{(exu_pkg::xlen-1){1'b0}}, a < b};
      exu_pkg::mode_sra:  raw = $signed(a) >>> shamt;
      exu_pkg::mode_sll:  raw = a << shamt;
      default:            raw = a + b;
    endcase
  end

  assign alu_result = alu_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

//--- source/exu_commit.sv
module exu_commit (
  input  logic                          stage_valid,
  input  exu_pkg::op_t                  stage_op,
  input  logic [exu_pkg::reg_idx_w-1:0] stage_rd,
  input  logic [exu_pkg::xlen-1:0]      stage_pc,
  input  logic [exu_pkg::xlen-1:0]      stage_imm,
  input  logic [exu_pkg::xlen-1:0]      alu_result,
  input  logic [exu_pkg::xlen-1:0]      load_data,
  input  logic                          out_ready,
  output logic                          out_valid,
  output logic [exu_pkg::xlen-1:0]      out_pc,
  output logic [exu_pkg::xlen-1:0]      out_dnpc,
  output logic                          out_wen,
  output logic [exu_pkg::reg_idx_w-1:0] out_rd,
  output logic [exu_pkg::xlen-1:0]      out_wdata,
  output logic                          retire,
  output logic                          rf_wen,
  output logic [exu_pkg::reg_idx_w-1:0] rf_waddr,
  output logic [exu_pkg::xlen-1:0]      rf_wdata
);

  logic [exu_pkg::xlen-1:0] snpc;
  logic [exu_pkg::xlen-1:0] taken_pc;
  logic                     writes;

  assign snpc     = stage_pc + 64'd4;
  assign taken_pc = stage_pc + stage_imm;

  always_comb begin
    writes    = 1'b1;
    out_wdata = alu_result;
    out_dnpc  = snpc;
    case (stage_op)
      exu_pkg::op_lui: out_wdata = stage_imm;
      exu_pkg::op_jal: begin
        out_wdata = snpc;
        out_dnpc  = alu_result;
      end
      exu_pkg::op_jalr: begin
        out_wdata = snpc;
        out_dnpc  = {alu_result[exu_pkg::xlen-1:1], 1'b0};
      end
      exu_pkg::op_ld, exu_pkg::op_lw, exu_pkg::op_lbu: out_wdata = load_data;
      exu_pkg::op_sd, exu_pkg::op_sh: writes = 1'b0;
      // alu holds src1 - src2 here
      exu_pkg::op_beq: begin
        writes   = 1'b0;
        out_dnpc = (alu_result == '0) ? taken_pc : snpc;
      end
      exu_pkg::op_bne: begin
        writes   = 1'b0;
        out_dnpc = (alu_result != '0) ? taken_pc : snpc;
      end
      default: ;
    endcase
  end

  assign out_valid = stage_valid;
  assign out_pc    = stage_pc;
  assign out_rd    = stage_rd;
  assign out_wen   = writes && (stage_rd != '0);

  assign retire   = stage_valid && out_ready;
  assign rf_wen   = retire && out_wen;
  assign rf_waddr = stage_rd;
  assign rf_wdata = out_wdata;

endmodule

//--- source/exu_issue.sv
module exu_issue (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  exu_pkg::op_t                  in_op,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rd,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rs1,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rs2,
  input  logic [exu_pkg::xlen-1:0]      in_imm,
  input  logic [exu_pkg::xlen-1:0]      in_pc,
  input  logic                          retire,
  input  logic [exu_pkg::xlen-1:0]      rf_rdata1,
  input  logic [exu_pkg::xlen-1:0]      rf_rdata2,
  input  logic                          rf_wen,
  input  logic [exu_pkg::reg_idx_w-1:0] rf_waddr,
  input  logic [exu_pkg::xlen-1:0]      rf_wdata,
  output logic [exu_pkg::reg_idx_w-1:0] rs1_addr,
  output logic [exu_pkg::reg_idx_w-1:0] rs2_addr,
  output logic                          stage_valid,
  output exu_pkg::op_t                  stage_op,
  output logic [exu_pkg::reg_idx_w-1:0] stage_rd,
  output logic [exu_pkg::xlen-1:0]      stage_pc,
  output logic [exu_pkg::xlen-1:0]      stage_imm,
  output logic [exu_pkg::xlen-1:0]      stage_src1,
  output logic [exu_pkg::xlen-1:0]      stage_src2,
  output logic [exu_pkg::xlen-1:0]      alu_a,
  output logic [exu_pkg::xlen-1:0]      alu_b,
  output exu_pkg::alu_mode_t            alu_mode,
  output logic                          alu_word
);

  logic                     accept;
  logic [exu_pkg::xlen-1:0] src1;
  logic [exu_pkg::xlen-1:0] src2;
  logic [exu_pkg::xlen-1:0] op_a;
  logic [exu_pkg::xlen-1:0] op_b;
  exu_pkg::alu_mode_t       mode;
  logic                     word;

  assign in_ready = !stage_valid || retire;
  assign accept   = in_valid && in_ready;

  assign rs1_addr = in_rs1;
  assign rs2_addr = in_rs2;

  // forward the value being written back this cycle
  assign src1 = (rf_wen && rf_waddr == in_rs1) ? rf_wdata : rf_rdata1;
  assign src2 = (rf_wen && rf_waddr == in_rs2) ? rf_wdata : rf_rdata2;

  always_comb begin
    op_a = src1;
    op_b = in_imm;
    mode = exu_pkg::mode_add;
    word = 1'b0;
    case (in_op)
      exu_pkg::op_add: op_b = src2;
      exu_pkg::op_sub: begin
        op_b = src2;
        mode = exu_pkg::mode_sub;
      end
      exu_pkg::op_addw: begin
        op_b = src2;
        word = 1'b1;
      end
      exu_pkg::op_sllw: begin
        op_b = {{(exu_pkg::xlen-5){1'b0}}, src2[4:0]};
        mode = exu_pkg::mode_sll;
        word = 1'b1;
      end
      exu_pkg::op_sltiu: mode = exu_pkg::mode_sltu;
      exu_pkg::op_srai:  mode = exu_pkg::mode_sra;
      exu_pkg::op_slli:  mode = exu_pkg::mode_sll;
      exu_pkg::op_auipc, exu_pkg::op_jal: op_a = in_pc;
      // branches compare through the difference
      exu_pkg::op_beq, exu_pkg::op_bne: begin
        op_b = src2;
        mode = exu_pkg::mode_sub;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (accept) begin
      stage_valid <= 1'b1;
    end else if (retire) begin
      stage_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage_op   <= in_op;
      stage_rd   <= in_rd;
      stage_pc   <= in_pc;
      stage_imm  <= in_imm;
      stage_src1 <= src1;
      stage_src2 <= src2;
      alu_a      <= op_a;
      alu_b      <= op_b;
      alu_mode   <= mode;
      alu_word   <= word;
    end
  end

endmodule

//--- source/exu_pkg.sv
package exu_pkg;

  localparam int xlen      = 64;
  localparam int reg_idx_w = 5;
  localparam int op_w      = 5;
  localparam int mem_words = 256;
  localparam int mem_idx_w = 8;

  // local operation codes, one per supported instruction
  typedef enum logic [op_w-1:0] {
    op_add,
    op_sub,
    op_addw,
    op_sllw,
    op_addi,
    op_sltiu,
    op_srai,
    op_slli,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_ld,
    op_lw,
    op_lbu,
    op_sd,
    op_sh
  } op_t;

  // alu function select
  typedef enum logic [2:0] {
    mode_add,
    mode_sub,
    mode_sltu,
    mode_sra,
    mode_sll
  } alu_mode_t;

  // one memory word, seen as bytes or as 32-bit halves
  typedef union packed {
    logic [7:0][7:0]  bytes;
    logic [1:0][31:0] words;
  } mem_word_u;

endpackage

//--- source/exu_top.sv
module exu_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  exu_pkg::op_t                  in_op,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rd,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rs1,
  input  logic [exu_pkg::reg_idx_w-1:0] in_rs2,
  input  logic [exu_pkg::xlen-1:0]      in_imm,
  input  logic [exu_pkg::xlen-1:0]      in_pc,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [exu_pkg::xlen-1:0]      out_pc,
  output logic [exu_pkg::xlen-1:0]      out_dnpc,
  output logic                          out_wen,
  output logic [exu_pkg::reg_idx_w-1:0] out_rd,
  output logic [exu_pkg::xlen-1:0]      out_wdata
);

  logic [exu_pkg::reg_idx_w-1:0] rs1_addr;
  logic [exu_pkg::reg_idx_w-1:0] rs2_addr;
  logic [exu_pkg::xlen-1:0]      rf_rdata1;
  logic [exu_pkg::xlen-1:0]      rf_rdata2;
  logic                          rf_wen;
  logic [exu_pkg::reg_idx_w-1:0] rf_waddr;
  logic [exu_pkg::xlen-1:0]      rf_wdata;
  logic                          retire;

  logic                          stage_valid;
  exu_pkg::op_t                  stage_op;
  logic [exu_pkg::reg_idx_w-1:0] stage_rd;
  logic [exu_pkg::xlen-1:0]      stage_pc;
  logic [exu_pkg::xlen-1:0]      stage_imm;
  logic [exu_pkg::xlen-1:0]      stage_src1;
  logic [exu_pkg::xlen-1:0]      stage_src2;
  logic [exu_pkg::xlen-1:0]      alu_a;
  logic [exu_pkg::xlen-1:0]      alu_b;
  exu_pkg::alu_mode_t            alu_mode;
  logic                          alu_word;
  logic [exu_pkg::xlen-1:0]      alu_result;
  logic [exu_pkg::xlen-1:0]      load_data;

  exu_issue u_issue (
    .clk, .rst,
    .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_pc,
    .retire, .rf_rdata1, .rf_rdata2, .rf_wen, .rf_waddr, .rf_wdata,
    .rs1_addr, .rs2_addr,
    .stage_valid, .stage_op, .stage_rd, .stage_pc, .stage_imm,
    .stage_src1, .stage_src2, .alu_a, .alu_b, .alu_mode, .alu_word
  );

  reg_file u_reg_file (
    .clk, .rst, .rs1_addr, .rs2_addr, .rf_rdata1, .rf_rdata2,
    .rf_wen, .rf_waddr, .rf_wdata
  );

  alu u_alu (.alu_a, .alu_b, .alu_mode, .alu_word, .alu_result);

  lsu u_lsu (
    .clk, .rst, .stage_valid, .stage_op, .stage_src1, .stage_src2,
    .stage_imm, .retire, .load_data
  );

  exu_commit u_commit (
    .stage_valid, .stage_op, .stage_rd, .stage_pc, .stage_imm,
    .alu_result, .load_data,
    .out_ready, .out_valid, .out_pc, .out_dnpc, .out_wen, .out_rd, .out_wdata,
    .retire, .rf_wen, .rf_waddr, .rf_wdata
  );

endmodule

//--- source/lsu.sv
module lsu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stage_valid,
  input  exu_pkg::op_t             stage_op,
  input  logic [exu_pkg::xlen-1:0] stage_src1,
  input  logic [exu_pkg::xlen-1:0] stage_src2,
  input  logic [exu_pkg::xlen-1:0] stage_imm,
  input  logic                     retire,
  output logic [exu_pkg::xlen-1:0] load_data
);

  exu_pkg::mem_word_u mem [exu_pkg::mem_words];

  logic [exu_pkg::xlen-1:0]      addr;
  logic [exu_pkg::mem_idx_w-1:0] idx;
  exu_pkg::mem_word_u            rd_word;
  exu_pkg::mem_word_u            wr_word;
  logic [31:0]                   half_sel;
  logic                          store_en;

  assign addr = stage_src1 + stage_imm;
  // byte offset bits are dropped, no misaligned handling
  assign idx  = addr[10:3];

  assign rd_word  = mem[idx];
  assign half_sel = rd_word.words[addr[2]];

  always_comb begin
    case (stage_op)
      exu_pkg::op_ld:  load_data = rd_word;
      exu_pkg::op_lw:  load_data = {{32{half_sel[31]}}, half_sel};
      exu_pkg::op_lbu: load_data = {56'b0, rd_word.bytes[addr[2:0]]};
      default:         load_data = '0;
    endcase
  end

  // read-modify-write merge for partial stores
  always_comb begin
    wr_word = rd_word;
    if (stage_op == exu_pkg::op_sd) begin
      wr_word = stage_src2;
    end else begin
      wr_word.bytes[{addr[2:1], 1'b0}] = stage_src2[7:0];
      wr_word.bytes[{addr[2:1], 1'b1}] = stage_src2[15:8];
    end
  end

  assign store_en = stage_valid && retire &&
                    (stage_op == exu_pkg::op_sd || stage_op == exu_pkg::op_sh);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < exu_pkg::mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (store_en) begin
      mem[idx] <= wr_word;
    end
  end

endmodule

//--- source/reg_file.sv
module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [exu_pkg::reg_idx_w-1:0] rs1_addr,
  input  logic [exu_pkg::reg_idx_w-1:0] rs2_addr,
  output logic [exu_pkg::xlen-1:0]      rf_rdata1,
  output logic [exu_pkg::xlen-1:0]      rf_rdata2,
  input  logic                          rf_wen,
  input  logic [exu_pkg::reg_idx_w-1:0] rf_waddr,
  input  logic [exu_pkg::xlen-1:0]      rf_wdata
);

  logic [exu_pkg::xlen-1:0] regs [2**exu_pkg::reg_idx_w];

  // x0 stays zero since commit never asserts rf_wen for rd 0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**exu_pkg::reg_idx_w; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wen) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // no bypass, issue forwards the retiring value itself
  assign rf_rdata1 = regs[rs1_addr];
  assign rf_rdata2 = regs[rs2_addr];

endmodule

//--- include/exu_tb_model.svh
`ifndef exu_tb_model_svh
`define exu_tb_model_svh

typedef struct packed {
  logic [exu_pkg::xlen-1:0]      pc;
  logic [exu_pkg::xlen-1:0]      dnpc;
  logic                          wen;
  logic [exu_pkg::reg_idx_w-1:0] rd;
  logic [exu_pkg::xlen-1:0]      wdata;
} expect_t;

logic [exu_pkg::xlen-1:0] model_regs [32];
logic [exu_pkg::xlen-1:0] model_mem [exu_pkg::mem_words];
logic [exu_pkg::xlen-1:0] model_next_pc;
expect_t                  expect_q [$];

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < exu_pkg::mem_words; i++) begin
    model_mem[i] = '0;
  end
  model_next_pc = 64'h0000_0000_8000_0000;
endtask

function automatic logic [63:0] sext_word(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// one accepted item, in program order
task automatic model_apply(input exu_pkg::op_t op, input logic [4:0] rd, rs1, rs2,
                           input logic [63:0] imm, pc);
  logic [63:0] a, b, addr, word, res;
  expect_t     e;
  a      = model_regs[rs1];
  b      = model_regs[rs2];
  addr   = a + imm;
  word   = model_mem[addr[10:3]];
  res    = '0;
  e.pc   = pc;
  e.dnpc = pc + 64'd4;
  e.rd   = rd;
  e.wen  = 1'b1;
  case (op)
    exu_pkg::op_add:   res = a + b;
    exu_pkg::op_sub:   res = a - b;
    exu_pkg::op_addw:  res = sext_word(a[31:0] + b[31:0]);
    exu_pkg::op_sllw:  res = sext_word(a[31:0] << b[4:0]);
    exu_pkg::op_addi:  res = a + imm;
    exu_pkg::op_sltiu: res = (a < imm) ? 64'd1 : 64'd0;
    exu_pkg::op_srai:  res = $signed(a) >>> imm[5:0];
    exu_pkg::op_slli:  res = a << imm[5:0];
    exu_pkg::op_lui:   res = imm;
    exu_pkg::op_auipc: res = pc + imm;
    exu_pkg::op_jal: begin
      res    = pc + 64'd4;
      e.dnpc = pc + imm;
    end
    exu_pkg::op_jalr: begin
      res    = pc + 64'd4;
      e.dnpc = (a + imm) & ~64'd1;
    end
    exu_pkg::op_beq: begin
      e.wen = 1'b0;
      if (a == b) begin
        e.dnpc = pc + imm;
      end
    end
    exu_pkg::op_bne: begin
      e.wen = 1'b0;
      if (a != b) begin
        e.dnpc = pc + imm;
      end
    end
    exu_pkg::op_ld:  res = word;
    exu_pkg::op_lw:  res = sext_word(addr[2] ? word[63:32] : word[31:0]);
    exu_pkg::op_lbu: res = {56'd0, word[8*addr[2:0] +: 8]};
    exu_pkg::op_sd: begin
      e.wen = 1'b0;
      model_mem[addr[10:3]] = b;
    end
    exu_pkg::op_sh: begin
      e.wen = 1'b0;
      word[16*addr[2:1] +: 16] = b[15:0];
      model_mem[addr[10:3]] = word;
    end
    default: ;
  endcase
  // x0 is hardwired
  if (rd == 5'd0) begin
    e.wen = 1'b0;
  end
  e.wdata = res;
  if (e.wen) begin
    model_regs[rd] = res;
  end
  model_next_pc = e.dnpc;
  expect_q.push_back(e);
endtask

`endif

//--- verif/exu_tb.sv
module exu_tb;

  localparam int num_random    = 400;
  localparam int num_zero_reads = 32;
  localparam int timeout_cycles = (num_random + num_zero_reads) * 8 + 100;

  `include "exu_tb_model.svh"

  logic                          clk;
  logic                          rst;
  logic                          in_valid;
  logic                          in_ready;
  exu_pkg::op_t                  in_op;
  logic [exu_pkg::reg_idx_w-1:0] in_rd;
  logic [exu_pkg::reg_idx_w-1:0] in_rs1;
  logic [exu_pkg::reg_idx_w-1:0] in_rs2;
  logic [exu_pkg::xlen-1:0]      in_imm;
  logic [exu_pkg::xlen-1:0]      in_pc;
  logic                          out_valid;
  logic                          out_ready;
  logic [exu_pkg::xlen-1:0]      out_pc;
  logic [exu_pkg::xlen-1:0]      out_dnpc;
  logic                          out_wen;
  logic [exu_pkg::reg_idx_w-1:0] out_rd;
  logic [exu_pkg::xlen-1:0]      out_wdata;

  logic [63:0] rng_state = 64'd15;
  int          pc_errors = 0;
  int          write_errors = 0;
  int          protocol_errors = 0;
  int          hang_errors = 0;
  int          accepted_count = 0;
  int          retired_count = 0;
  int          cycle_count = 0;
  logic        stalled = 1'b0;
  expect_t     held;
  expect_t     popped;

  tb_clock u_clock (.clk);

  exu_top u_dut (
    .clk, .rst, .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_pc,
    .out_valid, .out_ready, .out_pc, .out_dnpc, .out_wen, .out_rd, .out_wdata
  );

  function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic logic one_in_four();
    logic [63:0] r;
    r = next_rand();
    return r[1:0] == 2'b00;
  endfunction

  task automatic check_pc(input logic [exu_pkg::xlen-1:0] got_pc, got_dnpc,
                          input logic [exu_pkg::xlen-1:0] exp_pc, exp_dnpc);
    if (got_pc !== exp_pc || got_dnpc !== exp_dnpc) begin
      pc_errors++;
      $display("Fail %0t: pc %h dnpc %h, expected pc %h dnpc %h",
               $time, got_pc, got_dnpc, exp_pc, exp_dnpc);
    end
  endtask

  task automatic check_write(input logic got_wen, input logic [exu_pkg::reg_idx_w-1:0] got_rd,
                             input logic [exu_pkg::xlen-1:0] got_data,
                             input logic exp_wen, input logic [exu_pkg::reg_idx_w-1:0] exp_rd,
                             input logic [exu_pkg::xlen-1:0] exp_data);
    // write data only matters when the register is written
    if (got_wen !== exp_wen || got_rd !== exp_rd || (exp_wen && got_data !== exp_data)) begin
      write_errors++;
      $display("Fail %0t: wen %b rd %0d data %h, expected wen %b rd %0d data %h",
               $time, got_wen, got_rd, got_data, exp_wen, exp_rd, exp_data);
    end
  endtask

  task automatic final_report();
    $display("errors: pc %0d, write %0d, protocol %0d, timeout %0d",
             pc_errors, write_errors, protocol_errors, hang_errors);
    if (pc_errors + write_errors + protocol_errors + hang_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    out_ready = !one_in_four();
  endtask

  task automatic send_item(input exu_pkg::op_t op, input logic [4:0] rd, rs1, rs2,
                           input logic [63:0] imm);
    logic took;
    while (one_in_four()) begin
      in_valid = 1'b0;
      next_cycle();
    end
    in_op    = op;
    in_rd    = rd;
    in_rs1   = rs1;
    in_rs2   = rs2;
    in_imm   = imm;
    in_pc    = model_next_pc;
    in_valid = 1'b1;
    took     = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = in_ready;
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic send_random();
    logic [63:0]  r;
    logic [4:0]   code;
    exu_pkg::op_t op;
    logic [4:0]   rs1;
    logic [63:0]  imm;
    r    = next_rand();
    code = 5'(r % 64'd19);
    op   = exu_pkg::op_t'(code);
    r    = next_rand();
    rs1  = {2'b00, r[2:0]};
    imm  = {{52{r[31]}}, r[31:20]};
    case (op)
      exu_pkg::op_srai, exu_pkg::op_slli: imm = {58'd0, r[45:40]};
      exu_pkg::op_lui, exu_pkg::op_auipc: imm = {{32{r[63]}}, r[63:44], 12'd0};
      exu_pkg::op_jal, exu_pkg::op_beq, exu_pkg::op_bne: imm = {{51{r[52]}}, r[52:41], 1'b0};
      // x0 base on about half of them keeps the offsets colliding
      exu_pkg::op_ld, exu_pkg::op_lw, exu_pkg::op_lbu, exu_pkg::op_sd, exu_pkg::op_sh: begin
        if (r[9]) begin
          rs1 = '0;
        end
        imm = {58'd0, r[50:45]};
      end
      default: ;
    endcase
    send_item(op, {2'b00, r[5:3]}, rs1, {2'b00, r[8:6]}, imm);
  endtask

  // model, ordering and stall checks on stable values
  always @(negedge clk) begin
    if (!rst) begin
      if (stalled) begin
        if (out_valid !== 1'b1) begin
          protocol_errors++;
          $display("out_valid dropped at %0t while the output was stalled", $time);
        end
        check_pc(out_pc, out_dnpc, held.pc, held.dnpc);
        check_write(out_wen, out_rd, out_wdata, held.wen, held.rd, held.wdata);
      end
      stalled = out_valid && !out_ready;
      held    = {out_pc, out_dnpc, out_wen, out_rd, out_wdata};
      if (out_valid && out_ready) begin
        retired_count++;
        if (expect_q.size() == 0) begin
          protocol_errors++;
          $display("an item retired at %0t that was never accepted", $time);
        end else begin
          popped = expect_q.pop_front();
          check_pc(out_pc, out_dnpc, popped.pc, popped.dnpc);
          check_write(out_wen, out_rd, out_wdata, popped.wen, popped.rd, popped.wdata);
        end
      end
      if (in_valid && in_ready) begin
        model_apply(in_op, in_rd, in_rs1, in_rs2, in_imm, in_pc);
        accepted_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      hang_errors++;
      $display("the run hung: no finish after %0d cycles", cycle_count);
      final_report();
    end
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_op     = exu_pkg::op_add;
    in_rd     = '0;
    in_rs1    = '0;
    in_rs2    = '0;
    in_imm    = '0;
    in_pc     = '0;
    out_ready = 1'b0;
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      protocol_errors++;
      $display("after reset the stage is not empty or does not take input");
    end
    next_cycle();
    // every register reads zero after reset
    for (int i = 0; i < num_zero_reads; i++) begin
      send_item(exu_pkg::op_add, 5'(i), 5'(i), 5'(i), '0);
    end
    for (int n = 0; n < num_random; n++) begin
      send_random();
    end
    while (expect_q.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    if (accepted_count != retired_count) begin
      protocol_errors++;
      $display("accepted %0d items but %0d retired", accepted_count, retired_count);
    end
    final_report();
  end

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  output logic clk
);

  // 10 unit period, first rising edge at 5
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule
